/* src.f */
+incdir+design
design/gbt_pkg.sv
design/gbt_tx_framer.sv
design/elink_delay_line.sv
design/gbt_rx_parser.sv
design/gbt_link_top.sv
tb/gbt_link_tb.sv

/* Bender.yml */
package:
  name: gbt_link

export_include_dirs:
  - design

sources:
  # synthesizable design, package first
  - include_dirs:
      - design
    files:
      - design/gbt_pkg.sv
      - design/gbt_tx_framer.sv
      - design/elink_delay_line.sv
      - design/gbt_rx_parser.sv
      - design/gbt_link_top.sv

  # loopback testbench, top module gbt_link_tb
  - target: simulation
    include_dirs:
      - design
    files:
      - tb/gbt_link_tb.sv

/* tb/gbt_link_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "gbt_defs.svh"

module gbt_link_tb;

  localparam int unsigned CLK_PERIOD  = 40;
  localparam int unsigned RST_CYCLES  = 16;
  localparam int unsigned NUM_TESTS   = 5;
  localparam int unsigned FRAME       = `GBT_FRAME_LEN;
  // snapshot wait + one superframe + deepest tap + margin
  localparam int unsigned DELIVER_WIN = 3 * FRAME + `GBT_DLY_DEPTH;
  localparam int unsigned SETTLE      = 3 * FRAME + `GBT_DLY_DEPTH;  // relock after tap change
  localparam int unsigned WATCHDOG_NS =
    (RST_CYCLES + NUM_TESTS * 20 * FRAME + 200) * CLK_PERIOD;

  logic                       clk40;
  logic                       rst_i;
  gbt_pkg::gbt_req_t          req_in;
  logic                       req_load;
  gbt_pkg::gbt_ttc_t          ttc_in;
  logic [`GBT_DLY_SEL_W-1:0]  dly_sel;
  logic                       corrupt;   // blank the payload of the looped word
  gbt_pkg::gbt_word_u         rx_word;

  wire gbt_pkg::gbt_word_u    tx_word;
  wire                        req_en;
  wire gbt_pkg::gbt_req_t     req_out;
  wire gbt_pkg::gbt_ttc_t     ttc_out;
  wire                        locked;

  logic [31:0]                lfsr_q;
  int unsigned                pulse_cnt;  // req_en_o pulses since last clear
  gbt_pkg::gbt_req_t          last_req;   // req_o seen with the last pulse
  int unsigned                value_errs;
  int unsigned                miss_errs;

  gbt_link_top u_gbt_link_top (
    .clk40      (clk40),
    .rst_i      (rst_i),
    .req_i      (req_in),
    .req_load_i (req_load),
    .ttc_i      (ttc_in),
    .rx_word_i  (rx_word),
    .dly_sel_i  (dly_sel),
    .tx_word_o  (tx_word),
    .req_en_o   (req_en),
    .req_o      (req_out),
    .ttc_o      (ttc_out),
    .locked_o   (locked)
  );

  // --------------------
  // clock, loopback, monitor
  // --------------------

  initial begin
    clk40 = 1'b0;
    forever #(CLK_PERIOD / 2) clk40 = ~clk40;
  end

  // elink loopback, ttc kept on a corrupted word
  always_comb begin
    rx_word = tx_word;
    if (corrupt) begin
      rx_word.data.payload = '0;
    end
  end

  // registered outputs, old values read at the edge
  always @(posedge clk40) begin
    if (!rst_i && req_en) begin
      pulse_cnt = pulse_cnt + 1;
      last_req  = req_out;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("STATUS: FAIL");
    $finish;
  end

  // --------------------
  // random numbers
  // --------------------

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int unsigned n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);  // one step per bit
      val    = {val[30:0], lfsr_q[0]};
    end
    return val;
  endfunction

  // a data slice equal to the marker could fake a lock
  function automatic logic has_marker_slice(input gbt_pkg::gbt_req_t r);
    logic [47:0] ad;
    logic        hit;
    ad  = {r.address, r.data};  // slices msb first, as sent
    hit = 1'b0;
    for (int i = 0; i < 8; i++) begin
      if (ad[47 - 6 * i -: 6] == `GBT_START_MARKER) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  function automatic gbt_pkg::gbt_req_t make_req();
    gbt_pkg::gbt_req_t r;
    logic [31:0]       bits;
    bits       = take_bits(1);
    r.wr_valid = 1'b1;
    r.wr_en    = bits[0];
    r.address  = 16'(take_bits(16));
    r.data     = take_bits(32);
    while (has_marker_slice(r)) begin
      r.address = 16'(take_bits(16));
      r.data    = take_bits(32);
    end
    return r;
  endfunction

  // --------------------
  // compare tasks
  // --------------------

  task automatic check_req(input gbt_pkg::gbt_req_t got, input gbt_pkg::gbt_req_t exp,
                           input string msg);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_ttc(input gbt_pkg::gbt_ttc_t got, input gbt_pkg::gbt_ttc_t exp,
                           input string msg);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s, got %b expected %b", $time, msg, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string msg);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s, got %b expected %b", $time, msg, got, exp);
      value_errs++;
    end
  endtask

  // --------------------
  // drive helpers
  // --------------------

  task automatic wait_cycles(input int unsigned n);
    repeat (n) @(negedge clk40);
  endtask

  task automatic load_req(input gbt_pkg::gbt_req_t r);
    req_in   = r;
    req_load = 1'b1;
    wait_cycles(1);
    req_load = 1'b0;
  endtask

  // returns on the falling edge where word 0 sits on tx_word_o
  task automatic wait_tx_marker();
    int unsigned waited;
    waited = 0;
    while (tx_word.data.payload != `GBT_START_MARKER && waited <= FRAME) begin
      wait_cycles(1);
      waited++;
    end
    if (tx_word.data.payload != `GBT_START_MARKER) begin
      $display("tx_word_o never showed the start marker within %0d cycles", FRAME + 1);
      miss_errs++;
    end
  endtask

  task automatic settle_link(input string what);
    wait_cycles(SETTLE);
    check_bit(locked, 1'b1, $sformatf("locked_o after %s", what));
  endtask

  // pulse_cnt is cleared by the caller before the load
  task automatic expect_delivery(input gbt_pkg::gbt_req_t exp, input string what);
    int unsigned waited;
    waited = 0;
    while (pulse_cnt == 0 && waited < DELIVER_WIN) begin
      wait_cycles(1);
      waited++;
    end
    if (pulse_cnt == 0) begin
      $display("no req_en_o pulse for %s within %0d cycles", what, DELIVER_WIN);
      miss_errs++;
    end else begin
      check_req(last_req, exp, $sformatf("%s, req_o", what));
      wait_cycles(2 * FRAME);  // a second pulse would land here
      check_bit(pulse_cnt == 1, 1'b1, $sformatf("%s, exactly one pulse", what));
    end
  endtask

  // --------------------
  // tests
  // --------------------

  task automatic single_write();
    gbt_pkg::gbt_req_t r;
    r         = make_req();
    pulse_cnt = 0;
    load_req(r);
    expect_delivery(r, "single write");
    check_bit(locked, 1'b1, "locked_o after single write");
  endtask

  task automatic idle_link();
    logic lost;
    lost      = 1'b0;
    pulse_cnt = 0;
    repeat (4 * FRAME) begin
      wait_cycles(1);
      if (locked !== 1'b1) begin
        lost = 1'b1;
      end
    end
    check_bit(lost, 1'b0, "locked_o dropped on idle link");
    check_bit(pulse_cnt == 0, 1'b1, "no req_en_o on idle link");
  endtask

  task automatic overwrite_pending();
    gbt_pkg::gbt_req_t first;
    gbt_pkg::gbt_req_t second;
    first  = make_req();
    second = make_req();
    while (second == first) begin
      second = make_req();
    end
    wait_tx_marker();  // early in the superframe
    pulse_cnt = 0;
    load_req(first);
    load_req(second);  // back to back, latest wins
    expect_delivery(second, "overwritten request");
  endtask

  task automatic check_tap(input logic [`GBT_DLY_SEL_W-1:0] sel);
    gbt_pkg::gbt_ttc_t old_ttc;
    gbt_pkg::gbt_ttc_t flip;
    gbt_pkg::gbt_req_t r;
    dly_sel = sel;
    settle_link($sformatf("tap %0d", sel));
    old_ttc = ttc_in;
    flip    = '0;
    while (flip == '0) begin
      flip = 4'(take_bits(4));
    end
    ttc_in = old_ttc ^ flip;
    // framer 1 cycle, delay line sel+1, parser 1
    wait_cycles(int'(sel) + 2);
    check_ttc(ttc_out, old_ttc, $sformatf("ttc_o one cycle early, tap %0d", sel));
    wait_cycles(1);
    check_ttc(ttc_out, old_ttc ^ flip, $sformatf("ttc_o at tap %0d", sel));
    r         = make_req();
    pulse_cnt = 0;
    load_req(r);
    expect_delivery(r, $sformatf("request at tap %0d", sel));
  endtask

  task automatic ttc_and_taps();
    check_tap(`GBT_DLY_SEL_W'(0));
    check_tap(`GBT_DLY_SEL_W'(5));
    check_tap(`GBT_DLY_SEL_W'(15));
    dly_sel = '0;
    settle_link("tap back to 0");
  endtask

  task automatic lock_loss_relock();
    gbt_pkg::gbt_req_t lost_req;
    gbt_pkg::gbt_req_t new_req;
    logic              dropped;
    int unsigned       waited;
    lost_req = make_req();
    new_req  = make_req();
    dropped  = 1'b0;
    waited   = 0;
    wait_tx_marker();
    pulse_cnt = 0;
    load_req(lost_req);
    wait_tx_marker();  // word 0 of the group carrying lost_req
    corrupt = 1'b1;
    wait_cycles(1);
    corrupt = 1'b0;
    while (!dropped && waited < FRAME + `GBT_DLY_DEPTH) begin
      wait_cycles(1);
      waited++;
      if (locked === 1'b0) begin
        dropped = 1'b1;
      end
    end
    check_bit(dropped, 1'b1, "locked_o fall after corrupted marker");
    wait_cycles(3 * FRAME);
    check_bit(pulse_cnt == 0, 1'b1, "no delivery from the broken group");
    check_bit(locked, 1'b1, "locked_o after relock");
    pulse_cnt = 0;
    load_req(new_req);
    expect_delivery(new_req, "request after relock");
  endtask

  // --------------------
  // main sequence
  // --------------------

  initial begin
    rst_i      = 1'b1;
    req_in     = '0;
    req_load   = 1'b0;
    ttc_in     = '0;
    dly_sel    = '0;
    corrupt    = 1'b0;
    lfsr_q     = 32'd89037;
    pulse_cnt  = 0;
    last_req   = '0;
    value_errs = 0;
    miss_errs  = 0;

    wait_cycles(RST_CYCLES);
    rst_i = 1'b0;
    check_bit(req_en, 1'b0, "req_en_o right after reset");
    check_bit(locked, 1'b0, "locked_o right after reset");
    wait_cycles(2);  // first marker reaches the parser

    single_write();
    idle_link();
    overwrite_pending();
    ttc_and_taps();
    lock_loss_relock();

    $display("errors: %0d wrong values, %0d missing events", value_errs, miss_errs);
    if (value_errs == 0 && miss_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* design/gbt_link_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "gbt_defs.svh"

module gbt_link_top (
  input  wire                       clk40,
  input  wire                       rst_i,

  // request and ttc into the framer
  input  wire gbt_pkg::gbt_req_t    req_i,
  input  wire                       req_load_i,
  input  wire gbt_pkg::gbt_ttc_t    ttc_i,

  // elink words
  input  wire gbt_pkg::gbt_word_u   rx_word_i,
  input  wire [`GBT_DLY_SEL_W-1:0]  dly_sel_i,
  output wire gbt_pkg::gbt_word_u   tx_word_o,

  // recovered side
  output wire                       req_en_o,
  output wire gbt_pkg::gbt_req_t    req_o,
  output wire gbt_pkg::gbt_ttc_t    ttc_o,
  output wire                       locked_o
);

  wire gbt_pkg::gbt_word_u dly_word;  // aligned rx word

  // --------------------
  // transmit
  // --------------------
  gbt_tx_framer u_framer (
    .clk40      (clk40),
    .rst_i      (rst_i),
    .req_i      (req_i),
    .req_load_i (req_load_i),
    .ttc_i      (ttc_i),
    .tx_word_o  (tx_word_o)
  );

  // --------------------
  // receive
  // --------------------
  elink_delay_line u_delay (
    .clk40  (clk40),
    .rst_i  (rst_i),
    .word_i (rx_word_i),
    .sel_i  (dly_sel_i),
    .word_o (dly_word)
  );

  gbt_rx_parser u_parser (
    .clk40    (clk40),
    .rst_i    (rst_i),
    .word_i   (dly_word),
    .req_en_o (req_en_o),
    .req_o    (req_o),
    .ttc_o    (ttc_o),
    .locked_o (locked_o)
  );

endmodule

`default_nettype wire

/* design/gbt_rx_parser.sv */
`timescale 1ns/1ns
`default_nettype none

`include "gbt_defs.svh"

module gbt_rx_parser (
  input  wire                      clk40,
  input  wire                      rst_i,
  input  wire gbt_pkg::gbt_word_u  word_i,     // from the delay line
  output logic                     req_en_o,   // one cycle pulse
  output gbt_pkg::gbt_req_t        req_o,      // held until next pulse
  output gbt_pkg::gbt_ttc_t        ttc_o,
  output logic                     locked_o    // 0 means hunting
);

  localparam int unsigned POS_W = $clog2(`GBT_FRAME_LEN);
  localparam logic [POS_W-1:0] LAST_POS = POS_W'(`GBT_FRAME_LEN - 1);
  localparam logic [POS_W-1:0] CTRL_POS = POS_W'(1);

  // addr/data bits before the last slice
  localparam int unsigned AD_W = (`GBT_FRAME_LEN - 3) * `GBT_PAYLOAD_W;

  logic [POS_W-1:0] pos_q;       // position of word_i in the group
  logic             wr_valid_q;  // from word 1
  logic             wr_en_q;
  logic [AD_W-1:0]  ad_q;        // payload history, words 2..8 at word 9
  logic             is_marker;
  logic             deliver;

  assign is_marker = (word_i.data.payload == `GBT_START_MARKER);

  // last word of a locked group with a valid request
  assign deliver = locked_o && (pos_q == LAST_POS) && wr_valid_q;

  // --------------------
  // lock and position
  // --------------------

  always_ff @(posedge clk40) begin
    if (rst_i) begin
      locked_o   <= 1'b0;
      pos_q      <= '0;
      wr_valid_q <= 1'b0;
      req_en_o   <= 1'b0;
      ttc_o      <= '0;
    end else begin
      ttc_o    <= word_i.data.ttc;  // every word carries ttc
      req_en_o <= deliver;

      if (!locked_o) begin
        // hunt, first marker counts as word 0
        if (is_marker) begin
          locked_o <= 1'b1;
          pos_q    <= CTRL_POS;
        end
      end else if ((pos_q == '0) && !is_marker) begin
        // marker missing where expected
        locked_o <= 1'b0;  // group dropped, back to hunt
        pos_q    <= '0;
      end else begin
        pos_q <= (pos_q == LAST_POS) ? '0 : pos_q + 1'b1;
        if (pos_q == CTRL_POS) begin
          wr_valid_q <= word_i.ctrl.wr_valid;
        end
      end
    end
  end

  // --------------------
  // request rebuild
  // --------------------

  always_ff @(posedge clk40) begin
    // msb first, only the last 7 slices matter
    ad_q <= {ad_q[AD_W-`GBT_PAYLOAD_W-1:0], word_i.data.payload};

    if (pos_q == CTRL_POS) begin
      wr_en_q <= word_i.ctrl.wr_en;
    end

    if (deliver) begin
      req_o.wr_en    <= wr_en_q;
      req_o.wr_valid <= wr_valid_q;
      // ad_q holds addr[15:0] and data[31:6], word_i the final slice
      {req_o.address, req_o.data} <= {ad_q, word_i.data.payload};
    end
  end

endmodule

`default_nettype wire

/* design/elink_delay_line.sv */
`timescale 1ns/1ns
`default_nettype none

`include "gbt_defs.svh"

module elink_delay_line (
  input  wire                       clk40,
  input  wire                       rst_i,
  input  wire gbt_pkg::gbt_word_u   word_i,
  input  wire [`GBT_DLY_SEL_W-1:0]  sel_i,   // delay is sel_i+1 cycles
  output gbt_pkg::gbt_word_u        word_o
);

  // stage 0 is one cycle old
  logic [gbt_pkg::GBT_WORD_W-1:0] stage_q [`GBT_DLY_DEPTH];
  logic [`GBT_DLY_SEL_W-1:0]      sel_q;    // registered tap

  always_ff @(posedge clk40) begin
    if (rst_i) begin
      for (int i = 0; i < `GBT_DLY_DEPTH; i++) begin
        stage_q[i] <= '0;  // flush to zero words
      end
      sel_q <= '0;
    end else begin
      stage_q[0] <= word_i;
      for (int i = 1; i < `GBT_DLY_DEPTH; i++) begin
        stage_q[i] <= stage_q[i-1];  // shift every cycle
      end
      sel_q <= sel_i;
    end
  end

  // --------------------
  // tap mux, like an srl address
  // --------------------
  assign word_o = stage_q[sel_q];

endmodule

`default_nettype wire

/* design/gbt_tx_framer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "gbt_defs.svh"

module gbt_tx_framer (
  input  wire                      clk40,
  input  wire                      rst_i,
  input  wire gbt_pkg::gbt_req_t   req_i,
  input  wire                      req_load_i,  // one cycle strobe
  input  wire gbt_pkg::gbt_ttc_t   ttc_i,       // level, sent in every word
  output gbt_pkg::gbt_word_u       tx_word_o
);

  localparam int unsigned POS_W = $clog2(`GBT_FRAME_LEN);
  localparam logic [POS_W-1:0] LAST_POS = POS_W'(`GBT_FRAME_LEN - 1);

  gbt_pkg::gbt_req_t  pend_q;    // latest loaded request
  gbt_pkg::gbt_req_t  send_q;    // request in the current superframe
  logic [POS_W-1:0]   pos_q;     // position of the word on tx_word_o
  logic [POS_W-1:0]   pos_nxt;
  logic               frame_wrap;
  gbt_pkg::gbt_word_u word_nxt;

  assign frame_wrap = (pos_q == LAST_POS);
  assign pos_nxt    = frame_wrap ? '0 : pos_q + 1'b1;

  // --------------------
  // request registers
  // --------------------

  always_ff @(posedge clk40) begin
    if (rst_i) begin
      pend_q.wr_valid <= 1'b0;
      send_q.wr_valid <= 1'b0;  // first superframe after reset is empty
    end else begin
      if (frame_wrap) begin  // word 0 goes out at this edge
        send_q          <= pend_q;
        pend_q.wr_valid <= 1'b0;
      end
      if (req_load_i) begin
        pend_q <= req_i;  // latest load wins
      end
    end
  end

  // --------------------
  // word mux
  // --------------------

  always_comb begin
    word_nxt          = '0;
    word_nxt.data.ttc = ttc_i;
    case (pos_nxt)
      4'd0: word_nxt.data.payload = `GBT_START_MARKER;
      4'd1: begin
        word_nxt.ctrl.wr_valid = send_q.wr_valid;
        word_nxt.ctrl.wr_en    = send_q.wr_en;
      end
      4'd2: word_nxt.data.payload = send_q.address[15:10];                       // addr0
      4'd3: word_nxt.data.payload = send_q.address[9:4];                         // addr1
      4'd4: word_nxt.data.payload = {send_q.address[3:0], send_q.data[31:30]};   // addr2
      4'd5: word_nxt.data.payload = send_q.data[29:24];                          // data0
      4'd6: word_nxt.data.payload = send_q.data[23:18];                          // data1
      4'd7: word_nxt.data.payload = send_q.data[17:12];                          // data2
      4'd8: word_nxt.data.payload = send_q.data[11:6];                           // data3
      4'd9: word_nxt.data.payload = send_q.data[5:0];                            // data4
      default: word_nxt.data.payload = '0;  // unreachable
    endcase
  end

  // output word and position
  always_ff @(posedge clk40) begin
    if (rst_i) begin
      pos_q                  <= '0;
      tx_word_o.data.ttc     <= '0;
      tx_word_o.data.payload <= `GBT_START_MARKER;  // word 0 held in reset
    end else begin
      pos_q     <= pos_nxt;
      tx_word_o <= word_nxt;
    end
  end

endmodule

`default_nettype wire

/* design/gbt_pkg.sv */
`default_nettype none

`include "gbt_defs.svh"

package gbt_pkg;

  // raw width of one elink frame word
  localparam int unsigned GBT_WORD_W = `GBT_TTC_W + `GBT_PAYLOAD_W;

  // --------------------
  // ttc bits, msb first on the link
  // --------------------
  typedef struct packed {
    logic l1a;
    logic calpulse;
    logic resync;
    logic bc0;
  } gbt_ttc_t;

  // one register request, 50 bits
  typedef struct packed {
    logic        wr_en;
    logic        wr_valid;
    logic [15:0] address;
    logic [31:0] data;
  } gbt_req_t;

  // word 1 layout
  typedef struct packed {
    gbt_ttc_t                  ttc;
    logic                      wr_valid;
    logic                      wr_en;
    logic [`GBT_PAYLOAD_W-3:0] zero;   // always sent as 0
  } gbt_ctrl_word_t;

  // marker and addr/data layout
  typedef struct packed {
    gbt_ttc_t                  ttc;
    logic [`GBT_PAYLOAD_W-1:0] payload;
  } gbt_data_word_t;

  // same 10 bits, decoded by word position
  typedef union packed {
    gbt_ctrl_word_t ctrl;
    gbt_data_word_t data;
  } gbt_word_u;

endpackage

`default_nettype wire

/* design/gbt_defs.svh */
`ifndef GBT_DEFS_SVH
`define GBT_DEFS_SVH

// --------------------
// superframe format
// --------------------

// words per superframe, marker + ctrl + 8 addr/data
`define GBT_FRAME_LEN     10
`define GBT_START_MARKER  6'h2A  // payload of word 0
`define GBT_PAYLOAD_W     6      // payload bits per word
`define GBT_TTC_W         4      // l1a, calpulse, resync, bc0

// --------------------
// elink delay line
// --------------------

`define GBT_DLY_DEPTH     16     // stages
`define GBT_DLY_SEL_W     4      // tap select width

`endif
